// File: build.f
dlxPkg.sv
ctrlIf.sv
execIf.sv
controlDecode.sv
execDecode.sv
stageReg.sv
decodeMerge.sv
dlxDecode.sv
dlxDecode_props.sv
tbDlxDecode.sv

// File: controlDecode.sv
`timescale 1ns/10ps

module controlDecode (
    input  logic [0:dlxPkg::InstrWidth-1] instruction,
    ctrlIf.source                         ctrl
);
    import dlxPkg::*;

    logic [5:0] opcode;

    assign opcode = instruction[0:5];

    always_comb begin
        ctrl.pcToReg    = 1'b0;
        ctrl.regToPc    = 1'b0;
        ctrl.jump       = 1'b0;
        ctrl.jumpNonReg = 1'b0;
        ctrl.branch     = 1'b0;
        ctrl.branchZero = 1'b0;
        ctrl.rType      = 1'b0;
        ctrl.fpRType    = 1'b0;
        ctrl.memToReg   = 1'b0;
        ctrl.memWrite   = 1'b0;
        ctrl.loadSign   = 1'b0;
        ctrl.dSize      = MemByte;
        ctrl.extOp      = 1'b1;  // signed unless addui/subui
        ctrl.lhiOp      = 1'b0;

        case (opcode)
            OpRType:   ctrl.rType = 1'b1;
            OpFpRType: ctrl.fpRType = 1'b1;
            OpJ, OpJal: begin
                ctrl.jump       = 1'b1;
                ctrl.jumpNonReg = 1'b1;
                ctrl.pcToReg    = opcode[0];  // low opcode bit marks the linking form
            end
            OpJr, OpJalr: begin
                ctrl.jump    = 1'b1;
                ctrl.regToPc = 1'b1;
                ctrl.pcToReg = opcode[0];
            end
            OpBeqz, OpBnez: begin
                ctrl.branch     = 1'b1;
                ctrl.branchZero = ~opcode[0];  // beqz
            end
            OpAddui, OpSubui: ctrl.extOp = 1'b0;
            OpLhi:            ctrl.lhiOp = 1'b1;
            OpLb, OpLbu: begin
                ctrl.memToReg = 1'b1;
                ctrl.loadSign = (opcode == OpLb);
                ctrl.dSize    = MemByte;
            end
            OpLh, OpLhu: begin
                ctrl.memToReg = 1'b1;
                ctrl.loadSign = (opcode == OpLh);
                ctrl.dSize    = MemHalf;
            end
            OpLw: begin
                ctrl.memToReg = 1'b1;
                ctrl.dSize    = MemWord;
            end
            OpSb: ctrl.memWrite = 1'b1;
            OpSh: begin
                ctrl.memWrite = 1'b1;
                ctrl.dSize    = MemHalf;
            end
            OpSw: begin
                ctrl.memWrite = 1'b1;
                ctrl.dSize    = MemWord;
            end
            default: ;  // alu immediates need nothing here
        endcase
    end

    // stores, plain jumps and branches leave the register file alone
    assign ctrl.storeOrJumpOrBranch = ctrl.memWrite | (ctrl.jump & ~ctrl.pcToReg) | ctrl.branch;

endmodule

// File: ctrlIf.sv
`timescale 1ns/10ps

interface ctrlIf;
    import dlxPkg::*;

    logic    pcToReg;
    logic    regToPc;
    logic    jump;
    logic    jumpNonReg;
    logic    branch;
    logic    branchZero;
    logic    rType;
    logic    fpRType;
    logic    memToReg;
    logic    memWrite;
    logic    loadSign;
    memSizeE dSize;
    logic    extOp;                // sign extend the immediate
    logic    lhiOp;
    logic    storeOrJumpOrBranch;  // opcode never writes an integer register

    modport source (
        output pcToReg, regToPc, jump, jumpNonReg, branch, branchZero,
               rType, fpRType, memToReg, memWrite, loadSign, dSize,
               extOp, lhiOp, storeOrJumpOrBranch
    );

    modport sink (
        input pcToReg, regToPc, jump, jumpNonReg, branch, branchZero,
              rType, fpRType, memToReg, memWrite, loadSign, dSize,
              extOp, lhiOp, storeOrJumpOrBranch
    );

endinterface

// File: decodeMerge.sv
`timescale 1ns/10ps

module decodeMerge #(
    parameter int DataWidth = 32
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          stall,
    input  logic                          instrValid,
    input  logic [0:dlxPkg::InstrWidth-1] instruction,
    ctrlIf.sink                           ctrl,
    execIf.sink                           exec,
    output dlxPkg::idExCtrlT              ctrlOut,
    output dlxPkg::idExOperT              operOut,
    output logic                          outValid
);
    import dlxPkg::*;

    logic                 zeroWord;
    logic                 live;
    logic [15:0]          imm16;
    logic [DataWidth-1:0] immExt;
    idExCtrlT             ctrlD;
    idExOperT             operD;

    assign zeroWord = (instruction == '0);  // nop
    assign live     = instrValid & ~zeroWord;
    assign imm16    = instruction[16:31];

    always_comb begin
        if (ctrl.lhiOp) begin
            immExt = {imm16, {(DataWidth - 16){1'b0}}};
        end else if (ctrl.extOp) begin
            immExt = {{(DataWidth - 16){imm16[15]}}, imm16};
        end else begin
            immExt = {{(DataWidth - 16){1'b0}}, imm16};
        end
    end

    always_comb begin
        ctrlD = '0;
        if (live) begin
            ctrlD.pcToReg    = ctrl.pcToReg;
            ctrlD.regToPc    = ctrl.regToPc;
            ctrlD.jump       = ctrl.jump;
            ctrlD.jumpNonReg = ctrl.jumpNonReg;
            ctrlD.branch     = ctrl.branch;
            ctrlD.branchZero = ctrl.branchZero;
            ctrlD.rType      = ctrl.rType;
            ctrlD.fpRType    = ctrl.fpRType;
            // movfp2i writes an integer register, movi2fp never does
            ctrlD.regWrite   = (exec.movFp2I | ~ctrl.storeOrJumpOrBranch) & ~exec.movI2Fp;
            ctrlD.fpRegWrite = exec.mul | exec.movI2Fp;
            ctrlD.memToReg   = ctrl.memToReg;
            ctrlD.memWrite   = ctrl.memWrite;
            ctrlD.loadSign   = ctrl.loadSign;
            ctrlD.dSize      = ctrl.dSize;
            ctrlD.aluCtrl    = exec.aluCtrl;
            ctrlD.mul        = exec.mul;
            ctrlD.movFp2I    = exec.movFp2I;
            ctrlD.movI2Fp    = exec.movI2Fp;
        end
    end

    // operand fields follow the word even when it is not valid
    assign operD.rs1    = instruction[6:10];
    assign operD.rs2    = instruction[11:15];
    assign operD.rd     = instruction[16:20];
    assign operD.immExt = MaxDataWidth'(immExt);

    stageReg #(.payloadT(idExCtrlT)) uCtrlReg (
        .clock(clock),
        .reset(reset),
        .stall(stall),
        .d    (ctrlD),
        .q    (ctrlOut)
    );

    stageReg #(.payloadT(idExOperT)) uOperReg (
        .clock(clock),
        .reset(reset),
        .stall(stall),
        .d    (operD),
        .q    (operOut)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            outValid <= 1'b0;
        end else if (!stall) begin
            outValid <= instrValid;
        end
    end

endmodule

// File: dlxDecode.sv
`timescale 1ns/10ps

module dlxDecode #(
    parameter int DataWidth = 32
) (
    input  logic                            clock,
    input  logic                            reset,
    input  logic [0:dlxPkg::InstrWidth-1]   instruction,
    input  logic                            instrValid,
    input  logic                            stall,
    output logic                            outValid,
    output logic                            pcToReg,
    output logic                            regToPc,
    output logic                            jump,
    output logic                            jumpNonReg,
    output logic                            branch,
    output logic                            branchZero,
    output logic                            rType,
    output logic                            fpRType,
    output logic                            regWrite,
    output logic                            fpRegWrite,
    output logic                            memToReg,
    output logic                            memWrite,
    output logic                            loadSign,
    output logic [1:0]                      dSize,
    output logic [3:0]                      aluCtrl,
    output logic                            mul,
    output logic                            movFp2I,
    output logic                            movI2Fp,
    output logic [dlxPkg::RegAddrWidth-1:0] rs1,
    output logic [dlxPkg::RegAddrWidth-1:0] rs2,
    output logic [dlxPkg::RegAddrWidth-1:0] rd,
    output logic [DataWidth-1:0]            immExt
);
    import dlxPkg::*;

    idExCtrlT ctrlOut;
    idExOperT operOut;

    ctrlIf ctrlBus ();
    execIf execBus ();

    // both decoders see the raw input word
    controlDecode uControl (
        .instruction(instruction),
        .ctrl       (ctrlBus)
    );

    execDecode uExec (
        .instruction(instruction),
        .exec       (execBus)
    );

    decodeMerge #(.DataWidth(DataWidth)) uMerge (
        .clock      (clock),
        .reset      (reset),
        .stall      (stall),
        .instrValid (instrValid),
        .instruction(instruction),
        .ctrl       (ctrlBus),
        .exec       (execBus),
        .ctrlOut    (ctrlOut),
        .operOut    (operOut),
        .outValid   (outValid)
    );

    assign pcToReg    = ctrlOut.pcToReg;
    assign regToPc    = ctrlOut.regToPc;
    assign jump       = ctrlOut.jump;
    assign jumpNonReg = ctrlOut.jumpNonReg;
    assign branch     = ctrlOut.branch;
    assign branchZero = ctrlOut.branchZero;
    assign rType      = ctrlOut.rType;
    assign fpRType    = ctrlOut.fpRType;
    assign regWrite   = ctrlOut.regWrite;
    assign fpRegWrite = ctrlOut.fpRegWrite;
    assign memToReg   = ctrlOut.memToReg;
    assign memWrite   = ctrlOut.memWrite;
    assign loadSign   = ctrlOut.loadSign;
    assign dSize      = ctrlOut.dSize;
    assign aluCtrl    = ctrlOut.aluCtrl;
    assign mul        = ctrlOut.mul;
    assign movFp2I    = ctrlOut.movFp2I;
    assign movI2Fp    = ctrlOut.movI2Fp;
    assign rs1        = operOut.rs1;
    assign rs2        = operOut.rs2;
    assign rd         = operOut.rd;
    assign immExt     = operOut.immExt[DataWidth-1:0];  // upper bits unused below 64

endmodule

// File: dlxDecode_props.sv
`timescale 1ns/10ps

module dlxDecodeProps (
    input logic        clock,
    input logic        reset,
    input logic        outValid,
    input logic        memToReg,
    input logic        memWrite,
    input logic        regWrite,
    input logic        fpRegWrite,
    input logic        movI2Fp,
    input logic [21:0] ctrlBits  // every registered control output
);

    // a load never stores in the same word
    memExclusive: assert property (
        @(posedge clock) disable iff (reset) !(memToReg && memWrite)
    ) else $error("memToReg and memWrite high together");

    idleControlsZero: assert property (
        @(posedge clock) disable iff (reset) !outValid |-> (ctrlBits == '0)
    ) else $error("control outputs not cleared while outValid is low");

    // movi2fp targets the fp file only
    movI2FpSingleWrite: assert property (
        @(posedge clock) disable iff (reset) movI2Fp |-> !(regWrite && fpRegWrite)
    ) else $error("regWrite and fpRegWrite both high on movi2fp");

    validLowAfterReset: assert property (
        @(posedge clock) $fell(reset) |-> !outValid
    ) else $error("outValid high in the first cycle after reset");

endmodule

bind dlxDecode dlxDecodeProps propsCheck (
    .clock     (clock),
    .reset     (reset),
    .outValid  (outValid),
    .memToReg  (memToReg),
    .memWrite  (memWrite),
    .regWrite  (regWrite),
    .fpRegWrite(fpRegWrite),
    .movI2Fp   (movI2Fp),
    .ctrlBits  ({pcToReg, regToPc, jump, jumpNonReg, branch, branchZero, rType, fpRType,
                 regWrite, fpRegWrite, memToReg, memWrite, loadSign, dSize, aluCtrl,
                 mul, movFp2I, movI2Fp})
);

// File: dlxPkg.sv
package dlxPkg;

    localparam int InstrWidth   = 32;
    localparam int RegAddrWidth = 5;
    localparam int MaxDataWidth = 64;  // widest datapath the operand struct carries

    // opcodes, instruction bits 0..5
    localparam logic [5:0] OpRType   = 6'h00;
    localparam logic [5:0] OpFpRType = 6'h01;
    localparam logic [5:0] OpJ       = 6'h02;
    localparam logic [5:0] OpJal     = 6'h03;
    localparam logic [5:0] OpBeqz    = 6'h04;
    localparam logic [5:0] OpBnez    = 6'h05;
    localparam logic [5:0] OpAddi    = 6'h08;
    localparam logic [5:0] OpAddui   = 6'h09;
    localparam logic [5:0] OpSubi    = 6'h0a;
    localparam logic [5:0] OpSubui   = 6'h0b;
    localparam logic [5:0] OpAndi    = 6'h0c;
    localparam logic [5:0] OpOri     = 6'h0d;
    localparam logic [5:0] OpXori    = 6'h0e;
    localparam logic [5:0] OpLhi     = 6'h0f;
    localparam logic [5:0] OpJr      = 6'h12;
    localparam logic [5:0] OpJalr    = 6'h13;
    localparam logic [5:0] OpSlli    = 6'h14;
    localparam logic [5:0] OpSrli    = 6'h16;
    localparam logic [5:0] OpSrai    = 6'h17;
    localparam logic [5:0] OpSeqi    = 6'h18;
    localparam logic [5:0] OpSnei    = 6'h19;
    localparam logic [5:0] OpSlti    = 6'h1a;
    localparam logic [5:0] OpSgti    = 6'h1b;
    localparam logic [5:0] OpSlei    = 6'h1c;
    localparam logic [5:0] OpSgei    = 6'h1d;
    localparam logic [5:0] OpLb      = 6'h20;
    localparam logic [5:0] OpLh      = 6'h21;
    localparam logic [5:0] OpLw      = 6'h23;
    localparam logic [5:0] OpLbu     = 6'h24;
    localparam logic [5:0] OpLhu     = 6'h25;
    localparam logic [5:0] OpSb      = 6'h28;
    localparam logic [5:0] OpSh      = 6'h29;
    localparam logic [5:0] OpSw      = 6'h2b;

    // R-type function field, bits 26..31
    localparam logic [5:0] FnSll     = 6'h04;
    localparam logic [5:0] FnSrl     = 6'h06;
    localparam logic [5:0] FnSra     = 6'h07;
    localparam logic [5:0] FnAdd     = 6'h20;
    localparam logic [5:0] FnSub     = 6'h22;
    localparam logic [5:0] FnAnd     = 6'h24;
    localparam logic [5:0] FnOr      = 6'h25;
    localparam logic [5:0] FnXor     = 6'h26;
    localparam logic [5:0] FnSeq     = 6'h28;
    localparam logic [5:0] FnSne     = 6'h29;
    localparam logic [5:0] FnSlt     = 6'h2a;
    localparam logic [5:0] FnSgt     = 6'h2b;
    localparam logic [5:0] FnSle     = 6'h2c;
    localparam logic [5:0] FnSge     = 6'h2d;
    localparam logic [5:0] FnMovfp2i = 6'h34;
    localparam logic [5:0] FnMovi2fp = 6'h35;
    // FP-type function field
    localparam logic [5:0] FnMult    = 6'h0e;
    localparam logic [5:0] FnMultu   = 6'h16;

    typedef enum logic [3:0] {
        AluAdd = 4'b0000,
        AluSub = 4'b0001,
        AluSlt = 4'b0010,
        AluSle = 4'b0011,
        AluSgt = 4'b0100,
        AluSge = 4'b0101,
        AluSra = 4'b0111,
        AluSll = 4'b1001,
        AluSrl = 4'b1010,
        AluSeq = 4'b1011,
        AluSne = 4'b1100,
        AluAnd = 4'b1101,
        AluOr  = 4'b1110,
        AluXor = 4'b1111
    } aluOpE;

    typedef enum logic [1:0] {
        MemByte = 2'b00,
        MemHalf = 2'b01,
        MemWord = 2'b10
    } memSizeE;

    typedef struct packed {
        logic    pcToReg;
        logic    regToPc;
        logic    jump;
        logic    jumpNonReg;
        logic    branch;
        logic    branchZero;
        logic    rType;
        logic    fpRType;
        logic    regWrite;
        logic    fpRegWrite;
        logic    memToReg;
        logic    memWrite;
        logic    loadSign;
        memSizeE dSize;
        aluOpE   aluCtrl;
        logic    mul;
        logic    movFp2I;
        logic    movI2Fp;
    } idExCtrlT;

    // immExt sized for the widest datapath, narrower ones use the low bits
    typedef struct packed {
        logic [RegAddrWidth-1:0] rs1;
        logic [RegAddrWidth-1:0] rs2;
        logic [RegAddrWidth-1:0] rd;
        logic [MaxDataWidth-1:0] immExt;
    } idExOperT;

endpackage

// File: execDecode.sv
`timescale 1ns/10ps

module execDecode (
    input  logic [0:dlxPkg::InstrWidth-1] instruction,
    execIf.source                         exec
);
    import dlxPkg::*;

    logic [5:0] opcode;
    logic [5:0] func;

    assign opcode = instruction[0:5];
    assign func   = instruction[26:31];

    always_comb begin
        exec.aluCtrl = AluAdd;  // address arithmetic for loads, stores and jumps
        exec.mul     = 1'b0;
        exec.movFp2I = 1'b0;
        exec.movI2Fp = 1'b0;

        case (opcode)
            OpRType: begin
                case (func)
                    FnAdd:     exec.aluCtrl = AluAdd;
                    FnSub:     exec.aluCtrl = AluSub;
                    FnAnd:     exec.aluCtrl = AluAnd;
                    FnOr:      exec.aluCtrl = AluOr;
                    FnXor:     exec.aluCtrl = AluXor;
                    FnSll:     exec.aluCtrl = AluSll;
                    FnSrl:     exec.aluCtrl = AluSrl;
                    FnSra:     exec.aluCtrl = AluSra;
                    FnSeq:     exec.aluCtrl = AluSeq;
                    FnSne:     exec.aluCtrl = AluSne;
                    FnSlt:     exec.aluCtrl = AluSlt;
                    FnSgt:     exec.aluCtrl = AluSgt;
                    FnSle:     exec.aluCtrl = AluSle;
                    FnSge:     exec.aluCtrl = AluSge;
                    FnMovfp2i: exec.movFp2I = 1'b1;
                    FnMovi2fp: exec.movI2Fp = 1'b1;
                    default:   ;
                endcase
            end
            OpFpRType: begin
                // both multiply codes share one unit
                exec.mul = (func == FnMult) || (func == FnMultu);
            end
            OpAddi, OpAddui: exec.aluCtrl = AluAdd;
            OpSubi, OpSubui: exec.aluCtrl = AluSub;
            OpAndi:          exec.aluCtrl = AluAnd;
            OpOri:           exec.aluCtrl = AluOr;
            OpXori:          exec.aluCtrl = AluXor;
            OpSlli:          exec.aluCtrl = AluSll;
            OpSrli:          exec.aluCtrl = AluSrl;
            OpSrai:          exec.aluCtrl = AluSra;
            OpSeqi:          exec.aluCtrl = AluSeq;
            OpSnei:          exec.aluCtrl = AluSne;
            OpSlti:          exec.aluCtrl = AluSlt;
            OpSgti:          exec.aluCtrl = AluSgt;
            OpSlei:          exec.aluCtrl = AluSle;
            OpSgei:          exec.aluCtrl = AluSge;
            // lhi stays on add, the extender already shifted the immediate
            default:         exec.aluCtrl = AluAdd;
        endcase
    end

endmodule

// File: execIf.sv
`timescale 1ns/10ps

interface execIf;
    import dlxPkg::*;

    aluOpE aluCtrl;
    logic  mul;      // fp multiply, signed or unsigned
    logic  movFp2I;
    logic  movI2Fp;

    modport source (
        output aluCtrl,
        output mul,
        output movFp2I,
        output movI2Fp
    );

    modport sink (
        input aluCtrl,
        input mul,
        input movFp2I,
        input movI2Fp
    );

endinterface

// File: stageReg.sv
`timescale 1ns/10ps

module stageReg #(
    parameter type payloadT = logic
) (
    input  logic    clock,
    input  logic    reset,
    input  logic    stall,
    input  payloadT d,
    output payloadT q
);

    always_ff @(posedge clock) begin
        if (reset) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;  // stall keeps the previous stage contents
        end
    end

endmodule

// File: tbDlxDecode.sv
`timescale 1ns/10ps

module tbDlxDecode;
    import dlxPkg::*;

    logic        clock;
    logic        reset;
    logic [0:31] instruction;
    logic        instrValid;
    logic        stall;
    logic        outValid;
    logic        pcToReg;
    logic        regToPc;
    logic        jump;
    logic        jumpNonReg;
    logic        branch;
    logic        branchZero;
    logic        rType;
    logic        fpRType;
    logic        regWrite;
    logic        fpRegWrite;
    logic        memToReg;
    logic        memWrite;
    logic        loadSign;
    logic [1:0]  dSize;
    logic [3:0]  aluCtrl;
    logic        mul;
    logic        movFp2I;
    logic        movI2Fp;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] immExt;
    integer      seed;

    // alu functions first, the two moves last
    logic [5:0] rFuncs [16] = '{FnAdd, FnSub, FnAnd, FnOr, FnXor, FnSll, FnSrl, FnSra,
                                FnSeq, FnSne, FnSlt, FnSgt, FnSle, FnSge, FnMovfp2i, FnMovi2fp};
    logic [5:0] iOps [16] = '{OpAddi, OpAddui, OpSubi, OpSubui, OpAndi, OpOri, OpXori, OpSlli,
                              OpSrli, OpSrai, OpSeqi, OpSnei, OpSlti, OpSgti, OpSlei, OpSgei};
    logic [5:0] legalOps [33] = '{OpRType, OpFpRType, OpJ, OpJal, OpJr, OpJalr, OpBeqz,
                                  OpBnez, OpAddi, OpAddui, OpSubi, OpSubui, OpAndi, OpOri,
                                  OpXori, OpLhi, OpSlli, OpSrli, OpSrai, OpSeqi, OpSnei,
                                  OpSlti, OpSgti, OpSlei, OpSgei, OpLb, OpLh, OpLw, OpLbu,
                                  OpLhu, OpSb, OpSh, OpSw};

    dlxDecode #(.DataWidth(32)) uut (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic logic [0:31] makeR(input logic [5:0] op, input logic [4:0] src1,
                                          input logic [4:0] src2, input logic [4:0] dst,
                                          input logic [5:0] fn);
        return {op, src1, src2, dst, 5'b0, fn};
    endfunction

    function automatic logic [0:31] makeI(input logic [5:0] op, input logic [4:0] src1,
                                          input logic [4:0] dst, input logic [15:0] imm);
        return {op, src1, dst, imm};
    endfunction

    // codes straight from the alu operation table
    function automatic logic [3:0] expectAlu(input logic [5:0] op, input logic [5:0] fn);
        logic isR;
        isR = (op == OpRType);
        if ((isR && fn == FnSub) || op == OpSubi || op == OpSubui) return 4'b0001;
        if ((isR && fn == FnSlt) || op == OpSlti) return 4'b0010;
        if ((isR && fn == FnSle) || op == OpSlei) return 4'b0011;
        if ((isR && fn == FnSgt) || op == OpSgti) return 4'b0100;
        if ((isR && fn == FnSge) || op == OpSgei) return 4'b0101;
        if ((isR && fn == FnSra) || op == OpSrai) return 4'b0111;
        if ((isR && fn == FnSll) || op == OpSlli) return 4'b1001;
        if ((isR && fn == FnSrl) || op == OpSrli) return 4'b1010;
        if ((isR && fn == FnSeq) || op == OpSeqi) return 4'b1011;
        if ((isR && fn == FnSne) || op == OpSnei) return 4'b1100;
        if ((isR && fn == FnAnd) || op == OpAndi) return 4'b1101;
        if ((isR && fn == FnOr) || op == OpOri) return 4'b1110;
        if ((isR && fn == FnXor) || op == OpXori) return 4'b1111;
        return 4'b0000;  // add, also the address default
    endfunction

    function automatic idExCtrlT expectCtrl(input logic [0:31] w, input logic v);
        idExCtrlT   e;
        logic [5:0] op;
        logic [5:0] fn;
        logic       noWrite;
        op = w[0:5];
        fn = w[26:31];
        e = '0;
        if (v && w != 32'h0) begin
            e.rType      = (op == OpRType);
            e.fpRType    = (op == OpFpRType);
            e.jump       = (op == OpJ) || (op == OpJal) || (op == OpJr) || (op == OpJalr);
            e.jumpNonReg = (op == OpJ) || (op == OpJal);
            e.regToPc    = (op == OpJr) || (op == OpJalr);
            e.pcToReg    = (op == OpJal) || (op == OpJalr);
            e.branch     = (op == OpBeqz) || (op == OpBnez);
            e.branchZero = (op == OpBeqz);
            e.memToReg   = (op == OpLb) || (op == OpLh) || (op == OpLw) || (op == OpLbu)
                           || (op == OpLhu);
            e.memWrite   = (op == OpSb) || (op == OpSh) || (op == OpSw);
            e.loadSign   = (op == OpLb) || (op == OpLh);
            if ((op == OpLh) || (op == OpLhu) || (op == OpSh)) e.dSize = MemHalf;
            if ((op == OpLw) || (op == OpSw)) e.dSize = MemWord;
            e.aluCtrl    = aluOpE'(expectAlu(op, fn));
            e.mul        = (op == OpFpRType) && (fn == FnMult || fn == FnMultu);
            e.movFp2I    = (op == OpRType) && (fn == FnMovfp2i);
            e.movI2Fp    = (op == OpRType) && (fn == FnMovi2fp);
            noWrite      = e.memWrite || e.branch || (e.jump && !e.pcToReg);
            e.regWrite   = (e.movFp2I || !noWrite) && !e.movI2Fp;
            e.fpRegWrite = e.mul || e.movI2Fp;
        end
        return e;
    endfunction

    function automatic logic [31:0] expectImm(input logic [0:31] w);
        logic [15:0] imm;
        imm = w[16:31];
        if (w[0:5] == OpLhi) return {imm, 16'h0};
        if (w[0:5] == OpAddui || w[0:5] == OpSubui) return {16'h0, imm};
        return {{16{imm[15]}}, imm};
    endfunction

    task automatic checkValue(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic checkOutputs(input logic [0:31] w, input logic v);
        idExCtrlT e;
        e = expectCtrl(w, v);
        checkValue("outValid", outValid, v);
        checkValue("pcToReg", pcToReg, e.pcToReg);
        checkValue("regToPc", regToPc, e.regToPc);
        checkValue("jump", jump, e.jump);
        checkValue("jumpNonReg", jumpNonReg, e.jumpNonReg);
        checkValue("branch", branch, e.branch);
        checkValue("branchZero", branchZero, e.branchZero);
        checkValue("rType", rType, e.rType);
        checkValue("fpRType", fpRType, e.fpRType);
        checkValue("regWrite", regWrite, e.regWrite);
        checkValue("fpRegWrite", fpRegWrite, e.fpRegWrite);
        checkValue("memToReg", memToReg, e.memToReg);
        checkValue("memWrite", memWrite, e.memWrite);
        checkValue("loadSign", loadSign, e.loadSign);
        checkValue("dSize", dSize, e.dSize);
        checkValue("aluCtrl", aluCtrl, e.aluCtrl);
        checkValue("mul", mul, e.mul);
        checkValue("movFp2I", movFp2I, e.movFp2I);
        checkValue("movI2Fp", movI2Fp, e.movI2Fp);
        checkValue("rs1", rs1, w[6:10]);
        checkValue("rs2", rs2, w[11:15]);
        checkValue("rd", rd, w[16:20]);
        checkValue("immExt", immExt, expectImm(w));
    endtask

    task automatic waitOutValid(input logic level);
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (outValid !== level) begin
            cycles++;
            if (cycles > 20) begin
                $display("timed out waiting for outValid to become %0b", level);
                $display("Simulation failed");
                $fatal(1);
            end
            @(negedge clock);
        end
    endtask

    // one word, valid for a single capture edge
    task automatic applyInstr(input logic [0:31] w);
        @(posedge clock);
        instruction <= w;
        instrValid  <= 1'b1;
        @(posedge clock);
        instrValid  <= 1'b0;
        waitOutValid(1'b1);
        checkOutputs(w, 1'b1);
    endtask

    task automatic testReset();
        @(negedge clock);
        checkOutputs(32'h0, 1'b0);
        applyInstr(32'h0);  // nop still marks the slot valid
    endtask

    task automatic testAlu();
        int i;
        for (i = 0; i < 14; i++) begin
            applyInstr(makeR(OpRType, 5'(i), 5'(i + 3), 5'(31 - i), rFuncs[i]));
        end
        for (i = 0; i < 16; i++) begin
            applyInstr(makeI(iOps[i], 5'(i), 5'(i + 1), 16'hfff0 - 16'(i)));
            applyInstr(makeI(iOps[i], 5'(i + 2), 5'(i), 16'h0123 + 16'(i)));
        end
        applyInstr(makeI(OpLhi, 5'd0, 5'd5, 16'h8a5c));
    endtask

    task automatic testMemory();
        applyInstr(makeI(OpLb, 5'd1, 5'd2, 16'hfffc));
        applyInstr(makeI(OpLh, 5'd3, 5'd4, 16'h0010));
        applyInstr(makeI(OpLw, 5'd5, 5'd6, 16'h8000));
        applyInstr(makeI(OpLbu, 5'd7, 5'd8, 16'h7ffe));
        applyInstr(makeI(OpLhu, 5'd9, 5'd10, 16'hff00));
        applyInstr(makeI(OpSb, 5'd11, 5'd12, 16'h0004));
        applyInstr(makeI(OpSh, 5'd13, 5'd14, 16'hfff8));
        applyInstr(makeI(OpSw, 5'd15, 5'd16, 16'h1000));
    endtask

    task automatic testJumps();
        applyInstr(makeI(OpJ, 5'd0, 5'd0, 16'h0040));
        applyInstr(makeI(OpJal, 5'd3, 5'd1, 16'hffc0));
        applyInstr(makeI(OpJr, 5'd31, 5'd0, 16'h0000));
        applyInstr(makeI(OpJalr, 5'd12, 5'd0, 16'h0000));
        applyInstr(makeI(OpBeqz, 5'd4, 5'd0, 16'hfff4));
        applyInstr(makeI(OpBnez, 5'd6, 5'd0, 16'h000c));
    endtask

    task automatic testFp();
        applyInstr(makeR(OpFpRType, 5'd2, 5'd4, 5'd6, FnMult));
        applyInstr(makeR(OpFpRType, 5'd8, 5'd10, 5'd12, FnMultu));
        applyInstr(makeR(OpRType, 5'd1, 5'd0, 5'd3, FnMovi2fp));
        applyInstr(makeR(OpRType, 5'd5, 5'd0, 5'd7, FnMovfp2i));
    endtask

    task automatic testStall();
        logic [0:31] held;
        int          i;
        held = makeI(OpOri, 5'd7, 5'd9, 16'hbeef);
        @(posedge clock);
        instruction <= held;
        instrValid  <= 1'b1;
        @(posedge clock);
        stall <= 1'b1;  // raised just after the capture edge
        waitOutValid(1'b1);
        for (i = 0; i < 6; i++) begin
            @(posedge clock);
            instruction <= makeR(OpRType, 5'(i), 5'd3, 5'd4, FnSub);
            instrValid  <= i[0];
            @(negedge clock);
            checkOutputs(held, 1'b1);
        end
        @(posedge clock);
        stall      <= 1'b0;
        instrValid <= 1'b0;
        waitOutValid(1'b0);
    endtask

    // back to back words, each checked one cycle after its capture
    task automatic testRandom();
        logic [0:31] w;
        logic [0:31] prevW;
        logic        v;
        logic        prevV;
        logic [31:0] r;
        int          i;
        prevW = '0;
        prevV = 1'b0;
        for (i = 0; i < 200; i++) begin
            r = $random(seed);
            w = $random(seed);
            w[0:5] = legalOps[r[15:0] % 33];
            if (w[0:5] == OpRType) begin
                w[26:31] = rFuncs[r[31:16] % 16];
            end else if (w[0:5] == OpFpRType) begin
                w[26:31] = r[20] ? FnMult : FnMultu;
            end
            v = r[24] | r[25];
            @(posedge clock);
            instruction <= w;
            instrValid  <= v;
            if (i > 0) begin
                @(negedge clock);
                checkOutputs(prevW, prevV);
            end
            prevW = w;
            prevV = v;
        end
        @(posedge clock);
        instrValid <= 1'b0;  // last word captured here
        @(negedge clock);
        checkOutputs(prevW, prevV);
    endtask

    initial begin
        seed        = 76;
        reset       = 1'b1;
        instruction = '0;
        instrValid  = 1'b0;
        stall       = 1'b0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        testReset();
        testAlu();
        testMemory();
        testJumps();
        testFp();
        testStall();
        testRandom();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule
